// ==== project.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/mem_bus_if.sv
verilog/cpu_regs.sv
verilog/cpu_core.sv
verilog/data_ram.sv
verilog/prog_rom.sv
verilog/cpu_top.sv
verif/cpu_assert.sv
verif/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the cpu testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -j 0 \
  --top-module cpu_tb -f project.f -o cpu_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/cpu_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx 'All tests passed!' "$log"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb
  import isa_pkg::*;
();

  logic                    clk;
  logic                    rst_n;
  logic                    run;
  logic                    prog_we;
  logic [`CPU_ADDR_W-1:0]  prog_addr;
  logic [`CPU_INSTR_W-1:0] prog_wdata;
  logic                    ext_we;
  logic [`CPU_ADDR_W-1:0]  ext_addr;
  logic [`CPU_DATA_W-1:0]  ext_wdata;
  logic [`CPU_DATA_W-1:0]  ext_rdata;
  logic [`CPU_ADDR_W-1:0]  pc;
  logic [`CPU_DATA_W-1:0]  a;
  logic [`CPU_DATA_W-1:0]  b;
  logic [`CPU_ADDR_W-1:0]  x;
  logic [`CPU_ADDR_W-1:0]  y;
  logic                    carry;
  logic                    zero;
  logic                    instr_done;

  int                      errors;
  int                      timeouts;
  int                      checks;
  int                      seed;
  logic [`CPU_DATA_W-1:0]  pre_a, pre_b, pre_mx, pre_my;  // state before an instruction
  logic [`CPU_ADDR_W-1:0]  pre_pc;
  logic                    pre_c, pre_z;
  logic [`CPU_DATA_W-1:0]  exp_a, exp_b, exp_mx, exp_my;
  logic                    exp_c, exp_z;

  cpu_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_val(input string name, input logic [11:0] got, input logic [11:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic load_instr(input logic [11:0] addr, input logic [11:0] word);
    @(posedge clk);
    prog_we    <= 1'b1;
    prog_addr  <= addr;
    prog_wdata <= word;
    @(posedge clk);
    prog_we    <= 1'b0;
  endtask

  task automatic write_ram(input logic [11:0] addr, input logic [3:0] data);
    @(posedge clk);
    ext_we    <= 1'b1;
    ext_addr  <= addr;
    ext_wdata <= data;
    @(posedge clk);
    ext_we    <= 1'b0;
  endtask

  task automatic read_ram(input logic [11:0] addr, output logic [3:0] data);
    @(posedge clk);
    ext_we   <= 1'b0;
    ext_addr <= addr;
    @(posedge clk);  // synchronous read
    @(negedge clk);
    data = ext_rdata;
  endtask

  // one instruction, run dropped again in the done cycle
  task automatic run_instr();
    int n;
    n = 0;
    @(posedge clk);
    run <= 1'b1;
    @(negedge clk);
    while (!instr_done && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!instr_done) begin
      timeouts++;
      $display("Timeout: instr_done did not arrive within 20 cycles at %0t", $time);
    end
    @(posedge clk);
    run <= 1'b0;
  endtask

  function automatic logic [3:0] operand(input logic [1:0] sel);
    case (sel)
      2'd0:    return pre_a;
      2'd1:    return pre_b;
      2'd2:    return pre_mx;
      default: return pre_my;
    endcase
  endfunction

  function automatic void predict(input logic [11:0] word);
    int         op;
    logic [1:0] r;
    logic [3:0] qv;
    logic [3:0] res;
    logic [4:0] sum;
    op = -1;
    r  = word[5:4];
    qv = word[3:0];
    case (word[11:6])
      MOV_RI:  op = 0;
      ADD_RI:  op = 1;
      AND_RI:  op = 2;
      XOR_RI:  op = 3;
      default: op = -1;
    endcase
    if (op < 0) begin  // not an immediate form, try register form
      r  = word[3:2];
      qv = operand(word[1:0]);
      case (word[11:4])
        MOV_RQ:  op = 0;
        ADD_RQ:  op = 1;
        AND_RQ:  op = 2;
        XOR_RQ:  op = 3;
        default: op = -1;
      endcase
    end
    {exp_a, exp_b, exp_mx, exp_my, exp_c, exp_z} = {pre_a, pre_b, pre_mx, pre_my, pre_c, pre_z};
    if (op >= 0) begin
      sum = {1'b0, operand(r)} + {1'b0, qv};
      case (op)
        0:       res = qv;
        1: begin
          res   = sum[3:0];
          exp_c = sum[4];
        end
        2:       res = operand(r) & qv;
        default: res = operand(r) ^ qv;
      endcase
      exp_z = (res == 4'h0);
      case (r)
        2'd0:    exp_a  = res;
        2'd1:    exp_b  = res;
        2'd2:    exp_mx = res;
        default: exp_my = res;
      endcase
    end
  endfunction

  task automatic exec_and_check(input logic [11:0] word);
    logic [3:0] got_mx;
    logic [3:0] got_my;
    @(negedge clk);
    {pre_a, pre_b, pre_c, pre_z, pre_pc} = {a, b, carry, zero, pc};
    read_ram(x, pre_mx);
    read_ram(y, pre_my);
    load_instr(pre_pc, word);
    predict(word);
    run_instr();
    @(negedge clk);
    check_val("a", 12'(a), 12'(exp_a));
    check_val("b", 12'(b), 12'(exp_b));
    check_val("carry", 12'(carry), 12'(exp_c));
    check_val("zero", 12'(zero), 12'(exp_z));
    check_val("pc", pc, pre_pc + 12'd1);
    check_val("x", x, `X_RESET);
    check_val("y", y, `Y_RESET);
    read_ram(x, got_mx);
    read_ram(y, got_my);
    check_val("mem[x]", 12'(got_mx), 12'(exp_mx));
    check_val("mem[y]", 12'(got_my), 12'(exp_my));
  endtask

  function automatic logic [3:0] rand_nibble();
    return 4'($random(seed));
  endfunction

  function automatic logic [11:0] rq_word(input op_rq_e op, input logic [1:0] r,
                                          input logic [1:0] q);
    return {op, r, q};
  endfunction

  function automatic logic [11:0] ri_word(input op_ri_e op, input logic [1:0] r,
                                          input logic [3:0] imm);
    return {op, r, imm};
  endfunction

  task automatic set_operands(input logic [3:0] av, input logic [3:0] bv,
                              input logic [3:0] mxv, input logic [3:0] myv);
    write_ram(x, mxv);
    write_ram(y, myv);
    exec_and_check(ri_word(MOV_RI, 2'd0, av));
    exec_and_check(ri_word(MOV_RI, 2'd1, bv));
  endtask

  initial begin
    seed     = 32'h7282;
    errors   = 0;
    timeouts = 0;
    checks   = 0;
    {rst_n, run, prog_we, prog_addr, prog_wdata} = '0;
    {ext_we, ext_addr, ext_wdata} = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_val("pc", pc, 12'h000);
    check_val("a", 12'(a), 12'h000);
    check_val("b", 12'(b), 12'h000);
    check_val("flags", 12'({carry, zero, instr_done}), 12'h000);
    check_val("x", x, `X_RESET);
    check_val("y", y, `Y_RESET);

    set_operands(4'hf, 4'h1, 4'h0, 4'h0);
    exec_and_check(rq_word(ADD_RQ, 2'd0, 2'd1));  // leaves carry set for the xor runs
    for (int r = 0; r < 4; r++) begin
      for (int q = 0; q < 4; q++) begin
        set_operands(rand_nibble(), rand_nibble(), rand_nibble(), rand_nibble());
        exec_and_check(rq_word(XOR_RQ, 2'(r), 2'(q)));
      end
    end
    for (int r = 0; r < 4; r++) begin
      set_operands(rand_nibble(), rand_nibble(), rand_nibble(), rand_nibble());
      exec_and_check(ri_word(XOR_RI, 2'(r), rand_nibble()));
      exec_and_check(rq_word(MOV_RQ, 2'(r), 2'(r + 1)));
      exec_and_check(ri_word(MOV_RI, 2'(r), rand_nibble()));
      exec_and_check(rq_word(AND_RQ, 2'(r), 2'(r + 2)));
      exec_and_check(ri_word(AND_RI, 2'(r), rand_nibble()));
    end
    repeat (8) begin
      set_operands(rand_nibble(), rand_nibble(), rand_nibble(), rand_nibble());
      exec_and_check(rq_word(ADD_RQ, 2'(rand_nibble()), 2'(rand_nibble())));
      exec_and_check(ri_word(ADD_RI, 2'(rand_nibble()), rand_nibble()));
    end
    exec_and_check(12'hfff);  // undecoded, nop
    exec_and_check(12'h000);

    $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verif/cpu_assert.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_assert (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   run,
  input logic                   instr_done,
  input logic [`CPU_ADDR_W-1:0] pc,
  input logic [`CPU_DATA_W-1:0] a,
  input logic [`CPU_DATA_W-1:0] b,
  input logic [`CPU_ADDR_W-1:0] x,
  input logic [`CPU_ADDR_W-1:0] y,
  input logic                   carry,
  input logic                   zero
);

  logic busy;   // between the start edge and the end of the done cycle
  logic start;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (instr_done) begin
      busy <= 1'b0;
    end else if (run) begin
      busy <= 1'b1;
    end
  end

  assign start = run && !busy;  // fetch edge that latches an instruction

  a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    $past(start, `INSTR_CYCLES-1) |-> instr_done)
    else $error("instr_done missing %0d cycles after the start", `INSTR_CYCLES);

  a_done_only_on_time: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(instr_done) |-> $past(start, `INSTR_CYCLES-1))
    else $error("instr_done rose without a start %0d cycles earlier", `INSTR_CYCLES);

  a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    instr_done |=> !instr_done)
    else $error("instr_done high for more than one cycle");

  a_done_low_in_reset: assert property (@(posedge clk) !rst_n |-> !instr_done)
    else $error("instr_done high during reset");

  a_pc_on_done: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(pc) |-> instr_done)
    else $error("pc changed outside the done cycle");

  a_regs_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!run && !busy) |=> $stable({a, b, x, y, carry, zero}))
    else $error("registers changed while the core was halted");

endmodule

bind cpu_top cpu_assert i_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .run        (run),
  .instr_done (instr_done),
  .pc         (pc),
  .a          (a),
  .b          (b),
  .x          (x),
  .y          (y),
  .carry      (carry),
  .zero       (zero)
);

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top
  import isa_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    run,
  input  logic                    prog_we,
  input  logic [`CPU_ADDR_W-1:0]  prog_addr,
  input  logic [`CPU_INSTR_W-1:0] prog_wdata,
  input  logic                    ext_we,
  input  logic [`CPU_ADDR_W-1:0]  ext_addr,
  input  logic [`CPU_DATA_W-1:0]  ext_wdata,
  output logic [`CPU_DATA_W-1:0]  ext_rdata,
  output logic [`CPU_ADDR_W-1:0]  pc,
  output logic [`CPU_DATA_W-1:0]  a,
  output logic [`CPU_DATA_W-1:0]  b,
  output logic [`CPU_ADDR_W-1:0]  x,
  output logic [`CPU_ADDR_W-1:0]  y,
  output logic                    carry,
  output logic                    zero,
  output logic                    instr_done
);

  logic [`CPU_INSTR_W-1:0] instr;
  logic                    idle;
  opnd_sel_e               r_sel;
  logic                    wr_en;
  logic [`CPU_DATA_W-1:0]  wr_data;
  logic                    flag_we;
  logic                    new_carry;
  logic                    new_zero;
  logic [`CPU_ADDR_W-1:0]  sp;

  mem_bus_if i_mem_bus ();

  cpu_core i_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .instr      (instr),
    .pc         (pc),
    .idle       (idle),
    .instr_done (instr_done),
    .mem        (i_mem_bus.core),
    .r_sel      (r_sel),
    .q_sel      (),
    .a_val      (a),
    .b_val      (b),
    .x_val      (x),
    .y_val      (y),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .carry_in   (carry),
    .carry_out  (new_carry),
    .zero_out   (new_zero),
    .flag_we    (flag_we)
  );

  cpu_regs i_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_sel   (r_sel),
    .wr_data  (wr_data),
    .flag_we  (flag_we),
    .carry_in (new_carry),
    .zero_in  (new_zero),
    .a        (a),
    .b        (b),
    .x        (x),
    .y        (y),
    .sp       (sp),
    .carry    (carry),
    .zero     (zero)
  );

  data_ram i_ram (
    .clk       (clk),
    .mem       (i_mem_bus.mem),
    .idle      (idle),
    .ext_we    (ext_we),
    .ext_addr  (ext_addr),
    .ext_wdata (ext_wdata),
    .ext_rdata (ext_rdata)
  );

  prog_rom i_rom (
    .clk        (clk),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_wdata (prog_wdata),
    .pc         (pc),
    .instr      (instr)
  );

endmodule

// ==== verilog/prog_rom.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module prog_rom (
  input  logic                    clk,
  input  logic                    prog_we,
  input  logic [`CPU_ADDR_W-1:0]  prog_addr,
  input  logic [`CPU_INSTR_W-1:0] prog_wdata,
  input  logic [`CPU_ADDR_W-1:0]  pc,
  output logic [`CPU_INSTR_W-1:0] instr
);

  logic [`CPU_INSTR_W-1:0] rom [`ROM_DEPTH];

  // loaded only while run is low
  always_ff @(posedge clk) begin
    if (prog_we) rom[prog_addr] <= prog_wdata;
  end

  assign instr = rom[pc];  // async read, sampled by the core in fetch

endmodule

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module data_ram (
  input  logic                   clk,
  mem_bus_if.mem                 mem,
  input  logic                   idle,
  input  logic                   ext_we,
  input  logic [`CPU_ADDR_W-1:0] ext_addr,
  input  logic [`CPU_DATA_W-1:0] ext_wdata,
  output logic [`CPU_DATA_W-1:0] ext_rdata
);

  logic [`CPU_DATA_W-1:0] memory [`RAM_DEPTH];
  logic [`CPU_ADDR_W-1:0] addr;
  logic [`CPU_DATA_W-1:0] wdata;
  logic                   we;
  logic [`CPU_DATA_W-1:0] rdata_q;

  // outside port owns the array only while the core is halted in fetch
  assign addr  = idle ? ext_addr  : mem.addr;
  assign wdata = idle ? ext_wdata : mem.wdata;
  assign we    = idle ? ext_we    : mem.we;

  always_ff @(posedge clk) begin
    if (we) memory[addr] <= wdata;
    rdata_q <= memory[addr];  // old data on a write cycle
  end

  assign ext_rdata = rdata_q;
  assign mem.rdata = rdata_q;

endmodule

// ==== verilog/cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_core
  import isa_pkg::*, core_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    run,
  input  logic [`CPU_INSTR_W-1:0] instr,
  output logic [`CPU_ADDR_W-1:0]  pc,
  output logic                    idle,
  output logic                    instr_done,
  mem_bus_if.core                 mem,
  output opnd_sel_e               r_sel,
  output opnd_sel_e               q_sel,
  input  logic [`CPU_DATA_W-1:0]  a_val,
  input  logic [`CPU_DATA_W-1:0]  b_val,
  input  logic [`CPU_ADDR_W-1:0]  x_val,
  input  logic [`CPU_ADDR_W-1:0]  y_val,
  output logic                    wr_en,
  output logic [`CPU_DATA_W-1:0]  wr_data,
  input  logic                    carry_in,
  output logic                    carry_out,
  output logic                    zero_out,
  output logic                    flag_we
);

  seq_state_e             state;
  instr_u                 ir;
  alu_op_e                alu_op;
  logic                   use_imm;
  logic                   op_valid;
  logic [`CPU_DATA_W-1:0] imm;
  logic [`CPU_DATA_W-1:0] opr_r;
  logic [`CPU_DATA_W-1:0] result;
  logic                   res_carry;
  logic                   res_zero;

  alu_op_e                dec_op;
  logic                   dec_ri;
  logic                   dec_valid;
  opnd_sel_e              rd_sel;
  logic [`CPU_DATA_W-1:0] r_val;
  logic [`CPU_DATA_W-1:0] q_val;
  logic [`CPU_DATA_W:0]   sum;
  logic [`CPU_DATA_W-1:0] alu_res;
  logic                   alu_carry;

  // ri form wins when bits 11:6 carry a known immediate opcode
  always_comb begin
    dec_ri    = 1'b1;
    dec_valid = 1'b1;
    dec_op    = ALU_MOV;
    case (ir.ri.op)
      MOV_RI:  dec_op = ALU_MOV;
      ADD_RI:  dec_op = ALU_ADD;
      AND_RI:  dec_op = ALU_AND;
      XOR_RI:  dec_op = ALU_XOR;
      default: begin
        dec_ri = 1'b0;
        case (ir.rq.op)
          MOV_RQ:  dec_op = ALU_MOV;
          ADD_RQ:  dec_op = ALU_ADD;
          AND_RQ:  dec_op = ALU_AND;
          XOR_RQ:  dec_op = ALU_XOR;
          default: dec_valid = 1'b0;  // runs as a nop
        endcase
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_FETCH;
      pc       <= '0;
      op_valid <= 1'b0;
    end else begin
      case (state)
        S_FETCH:  if (run) state <= S_DECODE;
        S_DECODE: begin
          state    <= S_RD_R;
          op_valid <= dec_valid;
        end
        S_RD_R:   state <= S_RD_Q;
        S_RD_Q:   state <= S_EXEC;
        S_EXEC:   state <= S_WB;
        S_WB: begin
          state <= S_DONE;
          pc    <= pc + `CPU_ADDR_W'(1);  // visible together with the results
        end
        default:  state <= S_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      S_FETCH:  if (run) ir <= instr;
      S_DECODE: begin
        alu_op  <= dec_op;
        use_imm <= dec_ri;
        r_sel   <= dec_ri ? ir.ri.r : ir.rq.r;
        q_sel   <= ir.rq.q;
        imm     <= ir.ri.imm;
      end
      S_RD_Q:   opr_r <= r_val;  // ram data for r arrives this cycle
      S_EXEC: begin
        result    <= alu_res;
        res_carry <= alu_carry;
        res_zero  <= (alu_res == '0);
      end
      default: ;
    endcase
  end

  // q address only in S_RD_Q, r address for its read and for the write
  assign rd_sel   = (state == S_RD_Q) ? q_sel : r_sel;
  assign mem.addr = (rd_sel == OPND_MY) ? y_val : x_val;

  always_comb begin
    case (r_sel)
      OPND_A:  r_val = a_val;
      OPND_B:  r_val = b_val;
      default: r_val = mem.rdata;
    endcase
    if (use_imm) begin
      q_val = imm;
    end else begin
      case (q_sel)
        OPND_A:  q_val = a_val;
        OPND_B:  q_val = b_val;
        default: q_val = mem.rdata;
      endcase
    end
  end

  assign sum = {1'b0, opr_r} + {1'b0, q_val};

  always_comb begin
    alu_carry = carry_in;
    case (alu_op)
      ALU_MOV: alu_res = q_val;
      ALU_ADD: begin
        alu_res   = sum[`CPU_DATA_W-1:0];
        alu_carry = sum[`CPU_DATA_W];
      end
      ALU_AND: alu_res = opr_r & q_val;
      default: alu_res = opr_r ^ q_val;
    endcase
  end

  assign wr_en      = (state == S_WB) && op_valid;
  assign wr_data    = result;
  assign flag_we    = wr_en;
  assign carry_out  = res_carry;
  assign zero_out   = res_zero;
  assign mem.we     = wr_en && (r_sel inside {OPND_MX, OPND_MY});
  assign mem.wdata  = result;
  assign idle       = (state == S_FETCH) && !run;
  assign instr_done = (state == S_DONE);

endmodule

// ==== verilog/cpu_regs.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_regs
  import isa_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr_en,
  input  opnd_sel_e              wr_sel,
  input  logic [`CPU_DATA_W-1:0] wr_data,
  input  logic                   flag_we,
  input  logic                   carry_in,
  input  logic                   zero_in,
  output logic [`CPU_DATA_W-1:0] a,
  output logic [`CPU_DATA_W-1:0] b,
  output logic [`CPU_ADDR_W-1:0] x,
  output logic [`CPU_ADDR_W-1:0] y,
  output logic [`CPU_ADDR_W-1:0] sp,
  output logic                   carry,
  output logic                   zero
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a  <= '0;
      b  <= '0;
      x  <= `X_RESET;
      y  <= `Y_RESET;
      sp <= `SP_RESET;  // kept for the stack, nothing uses it yet
    end else if (wr_en) begin
      case (wr_sel)
        OPND_A:  a <= wr_data;
        OPND_B:  b <= wr_data;
        default: ;  // memory targets go out over the data bus
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      carry <= 1'b0;
      zero  <= 1'b0;
    end else if (flag_we) begin
      carry <= carry_in;  // alu passes the old carry through when untouched
      zero  <= zero_in;
    end
  end

endmodule

// ==== verilog/mem_bus_if.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

interface mem_bus_if;
  logic [`CPU_ADDR_W-1:0] addr;
  logic [`CPU_DATA_W-1:0] wdata;
  logic                   we;     // write on the clock edge
  logic [`CPU_DATA_W-1:0] rdata;  // valid the cycle after addr

  modport core (
    output addr, wdata, we,
    input  rdata
  );

  modport mem (
    input  addr, wdata, we,
    output rdata
  );
endinterface

// ==== verilog/core_pkg.sv ====
package core_pkg;

  // one state per cycle of an instruction
  typedef enum logic [2:0] {
    S_FETCH  = 3'd0,
    S_DECODE = 3'd1,
    S_RD_R   = 3'd2,
    S_RD_Q   = 3'd3,
    S_EXEC   = 3'd4,
    S_WB     = 3'd5,
    S_DONE   = 3'd6
  } seq_state_e;

  typedef enum logic [1:0] {
    ALU_MOV = 2'd0,
    ALU_ADD = 2'd1,
    ALU_AND = 2'd2,
    ALU_XOR = 2'd3
  } alu_op_e;

endpackage

// ==== verilog/isa_pkg.sv ====
`include "cpu_defs.svh"

package isa_pkg;

  typedef enum logic [1:0] {
    OPND_A  = 2'd0,
    OPND_B  = 2'd1,
    OPND_MX = 2'd2,  // data memory at x
    OPND_MY = 2'd3   // data memory at y
  } opnd_sel_e;

  // register/register forms, instruction bits 11:4
  typedef enum logic [7:0] {
    MOV_RQ = 8'ha0,
    ADD_RQ = 8'ha4,
    AND_RQ = 8'hac,
    XOR_RQ = 8'hae
  } op_rq_e;

  // register/immediate forms, instruction bits 11:6
  typedef enum logic [5:0] {
    MOV_RI = 6'h30,
    ADD_RI = 6'h31,
    AND_RI = 6'h32,
    XOR_RI = 6'h34
  } op_ri_e;

  typedef struct packed {
    op_rq_e    op;
    opnd_sel_e r;
    opnd_sel_e q;
  } instr_rq_t;

  typedef struct packed {
    op_ri_e                 op;
    opnd_sel_e              r;
    logic [`CPU_DATA_W-1:0] imm;
  } instr_ri_t;

  typedef union packed {
    instr_rq_t rq;
    instr_ri_t ri;
  } instr_u;

endpackage

// ==== verilog/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath and bus widths
`define CPU_DATA_W   4
`define CPU_ADDR_W   12
`define CPU_INSTR_W  12

// memory depths, one word per address
`define ROM_DEPTH    4096
`define RAM_DEPTH    4096

// pointer reset values
`define X_RESET      12'h000
`define Y_RESET      12'h279
`define SP_RESET     12'hfff  // top of data memory

// every instruction takes the same number of cycles
`define INSTR_CYCLES 7

`endif
